// ==== hw/nnFormatPkg.sv ====
package nnFormatPkg;

	////////////////////////////////////////
	// Number format
	////////////////////////////////////////

	// Features, weights, products and sums all share one word width.
	localparam int dataWidth = 32;

	// Q13 fixed point.
	localparam int fracBits = 13;

	// Activation is sum bits 28 down to 13.
	localparam int actWidth = 16;

	////////////////////////////////////////
	// Layer shape
	////////////////////////////////////////

	localparam int numInputs = 15; // Features per vector.
	localparam int numNeurons = 8; // Rectifying nodes in the layer.

	// Wide enough to index every neuron.
	localparam int classWidth = 3;

	////////////////////////////////////////
	// Flow control
	////////////////////////////////////////

	// Vectors allowed between the loader and the output stream.
	// The collector buffer holds exactly this many.
	localparam int maxInFlight = 2;

endpackage

// ==== hw/nnWeightsPkg.sv ====
package nnWeightsPkg;

	////////////////////////////////////////
	// Trained weights, Q13
	////////////////////////////////////////

	// One row per neuron and one column per feature.
	localparam logic signed [nnFormatPkg::dataWidth-1:0]
		layerWeights [nnFormatPkg::numNeurons][nnFormatPkg::numInputs] = '{
		'{1319, 3632, 2142, 230, -694, -3447, 3257, -3402,
			5201, 3106, 3539, 3934, -4976, 5076, -574},
		'{-2210, 4417, 905, -3120, 2788, 1604, -517, 3391,
			-4082, 2260, -1388, 4710, 833, -2954, 1772},
		'{3085, -1946, 4523, 1187, -3809, 620, 2915, -1453,
			3678, -4215, 1049, -267, 5340, 1826, -3011},
		'{-486, 2671, -3552, 4096, 1935, -2784, 3360, 718,
			-1127, 4859, -3906, 2043, -615, 3227, 4401},
		'{4732, 1058, -2389, -1744, 3516, 2402, -4650, 1290,
			2067, -932, 3815, -2561, 1479, -3688, 2936},
		'{-3375, -820, 1613, 3904, -2146, 4288, 1177, -3021,
			615, 3550, 2134, -4467, 2702, 944, -1805},
		'{2569, 3980, -1231, -4588, 902, 1867, -2733, 4145,
			3309, -1516, -2290, 1625, 3873, -905, 2348},
		'{1744, -3062, 3407, 2531, 4367, -1189, 686, -2478,
			-3735, 1952, 4623, 371, -2214, 2819, -4130}
	};

	////////////////////////////////////////
	// Biases, Q13
	////////////////////////////////////////

	localparam logic signed [nnFormatPkg::dataWidth-1:0]
		layerBias [nnFormatPkg::numNeurons] = '{
		-64,
		128,
		-256,
		96,
		-192,
		320,
		-32,
		160
	};

endpackage

// ==== hw/featureLoader.sv ====
`timescale 1ns/1ps

module featureLoader (
	input logic clk,
	input logic reset,
	input logic [nnFormatPkg::dataWidth-1:0] featData,
	input logic featValid,
	input logic featLast,
	output logic featReady,
	input logic creditAvail,
	output logic [nnFormatPkg::numInputs-1:0][nnFormatPkg::dataWidth-1:0] vecData,
	output logic vecValid,
	output logic frameError
);
	import nnFormatPkg::*;

	localparam int countWidth = $clog2(numInputs);

	logic [countWidth-1:0] beatCount;
	logic vecFull; // A complete vector waits in the shift register.
	logic beatTaken;
	logic lastBeat;

	// Stall only while a finished vector has nowhere to go.
	assign featReady = !vecFull || creditAvail;
	assign vecValid = vecFull && creditAvail;

	assign beatTaken = featValid && featReady;
	assign lastBeat = beatCount == countWidth'(numInputs - 1);

	////////////////////////////////////////
	// Shift register
	////////////////////////////////////////

	// Newest beat enters at the top, so the first feature ends at index 0.
	// On an issue cycle the neurons sample the old contents at this edge.
	always_ff @(posedge clk)
	begin
		if (beatTaken)
			vecData <= {featData, vecData[numInputs-1:1]};
	end

	////////////////////////////////////////
	// Beat count and framing
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			beatCount <= '0;
			vecFull <= 1'b0;
			frameError <= 1'b0;
		end
		else
		begin
			if (vecValid)
				vecFull <= 1'b0;
			if (beatTaken)
			begin
				if (featLast != lastBeat)
					frameError <= 1'b1; // Sticky until reset.
				if (lastBeat)
				begin
					beatCount <= '0;
					vecFull <= 1'b1;
				end
				else
					beatCount <= beatCount + 1'b1;
			end
		end
	end

	// Credit is used up only by a vector issued here.
	assert property (@(posedge clk) disable iff (reset) $fell(creditAvail) |-> $past(vecValid));
	// A stalled beat stays on the bus until it is taken.
	assert property (@(posedge clk) disable iff (reset)
		featValid && !featReady |=> featValid && $stable({featData, featLast}));

endmodule

// ==== hw/reluNeuron.sv ====
`timescale 1ns/1ps

module reluNeuron #(
	parameter int weightRow = 0
) (
	input logic clk,
	input logic reset,
	input logic [nnFormatPkg::numInputs-1:0][nnFormatPkg::dataWidth-1:0] vecData,
	input logic vecValid,
	output logic [nnFormatPkg::actWidth-1:0] act,
	output logic actValid
);
	import nnFormatPkg::*;
	import nnWeightsPkg::*;

	localparam int actMsb = fracBits + actWidth - 1;

	logic [numInputs-1:0][dataWidth-1:0] inReg;
	logic [dataWidth-1:0] prod [numInputs];
	logic [dataWidth-1:0] sumNext;
	logic [dataWidth-1:0] sumReg;
	logic inValid;
	logic sumValid;

	////////////////////////////////////////
	// Stage 1: input capture
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (vecValid)
			inReg <= vecData;
	end

	////////////////////////////////////////
	// Stage 2: weighted sum
	////////////////////////////////////////

	// Only the low word of each product is kept, so overflow wraps.
	always_comb
	begin
		for (int i = 0; i < numInputs; i++)
			prod[i] = inReg[i] * layerWeights[weightRow][i];
	end

	always_comb
	begin
		sumNext = layerBias[weightRow];
		for (int i = 0; i < numInputs; i++)
			sumNext = sumNext + prod[i];
	end

	always_ff @(posedge clk)
	begin
		if (inValid)
			sumReg <= sumNext;
	end

	////////////////////////////////////////
	// Stage 3: rectifier
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inValid <= 1'b0;
			sumValid <= 1'b0;
			actValid <= 1'b0;
			act <= '0;
		end
		else
		begin
			inValid <= vecValid;
			sumValid <= inValid;
			actValid <= sumValid;
			if (sumValid)
			begin
				if (sumReg[dataWidth-1])
					act <= '0; // Negative sum.
				else
					act <= sumReg[actMsb:fracBits];
			end
		end
	end

	// A valid bit never launches an unknown vector into the collector.
	assert property (@(posedge clk) disable iff (reset) !$isunknown({act, actValid}));

endmodule

// ==== hw/activationCollector.sv ====
`timescale 1ns/1ps

module activationCollector (
	input logic clk,
	input logic reset,
	input logic vecValid,
	input logic [nnFormatPkg::numNeurons-1:0][nnFormatPkg::actWidth-1:0] actData,
	input logic [nnFormatPkg::numNeurons-1:0] actValid,
	output logic creditAvail,
	output logic [nnFormatPkg::actWidth-1:0] outData,
	output logic [nnFormatPkg::classWidth-1:0] outIndex,
	output logic [nnFormatPkg::classWidth-1:0] outClass,
	output logic outLast,
	output logic outValid,
	input logic outReady
);
	import nnFormatPkg::*;

	localparam int flightWidth = $clog2(maxInFlight + 1);

	logic [flightWidth-1:0] inFlight;
	logic [numNeurons-1:0][actWidth-1:0] actBuf [maxInFlight];
	logic [classWidth-1:0] classBuf [maxInFlight];
	logic [maxInFlight-1:0] entryValid;
	logic wrPtr;
	logic rdPtr;
	logic [classWidth-1:0] beatIdx;
	logic [actWidth-1:0] bestAct;
	logic [classWidth-1:0] bestIdx;
	logic capture;
	logic beatDone;
	logic frameDone;

	assign capture = actValid[0]; // All neurons run in lockstep.
	assign beatDone = outValid && outReady;
	assign frameDone = beatDone && outLast;

	assign creditAvail = inFlight < flightWidth'(maxInFlight);

	////////////////////////////////////////
	// Credits
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
			inFlight <= '0;
		else
		begin
			case ({vecValid, frameDone})
				2'b10: inFlight <= inFlight + 1'b1;
				2'b01: inFlight <= inFlight - 1'b1;
				default: inFlight <= inFlight;
			endcase
		end
	end

	////////////////////////////////////////
	// Capture and class search
	////////////////////////////////////////

	// Strict compare, so the lowest index keeps a tie.
	always_comb
	begin
		bestAct = actData[0];
		bestIdx = '0;
		for (int i = 1; i < numNeurons; i++)
		begin
			if (actData[i] > bestAct)
			begin
				bestAct = actData[i];
				bestIdx = classWidth'(i);
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (capture)
		begin
			actBuf[wrPtr] <= actData;
			classBuf[wrPtr] <= bestIdx;
		end
	end

	////////////////////////////////////////
	// Output stream
	////////////////////////////////////////

	assign outValid = entryValid[rdPtr];
	assign outData = actBuf[rdPtr][beatIdx];
	assign outIndex = beatIdx;
	assign outClass = classBuf[rdPtr];
	assign outLast = beatIdx == classWidth'(numNeurons - 1);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			entryValid <= '0;
			wrPtr <= 1'b0;
			rdPtr <= 1'b0;
			beatIdx <= '0;
		end
		else
		begin
			if (capture)
			begin
				entryValid[wrPtr] <= 1'b1;
				wrPtr <= ~wrPtr;
			end
			if (frameDone)
			begin
				entryValid[rdPtr] <= 1'b0; // Slot is free again.
				rdPtr <= ~rdPtr;
				beatIdx <= '0;
			end
			else if (beatDone)
				beatIdx <= beatIdx + 1'b1;
		end
	end

	// The neurons fire together, and credits keep a slot free for each result.
	assert property (@(posedge clk) disable iff (reset)
		(actValid == '0) || (actValid == '1));
	assert property (@(posedge clk) disable iff (reset) capture |-> !entryValid[wrPtr]);

endmodule

// ==== hw/denseLayerTop.sv ====
`timescale 1ns/1ps

module denseLayerTop (
	input logic clk,
	input logic reset,
	input logic [nnFormatPkg::dataWidth-1:0] featData,
	input logic featValid,
	input logic featLast,
	output logic featReady,
	output logic [nnFormatPkg::actWidth-1:0] outData,
	output logic [nnFormatPkg::classWidth-1:0] outIndex,
	output logic [nnFormatPkg::classWidth-1:0] outClass,
	output logic outLast,
	output logic outValid,
	input logic outReady,
	output logic frameError
);
	import nnFormatPkg::*;

	logic [numInputs-1:0][dataWidth-1:0] vecData;
	logic vecValid;
	logic [numNeurons-1:0][actWidth-1:0] actData;
	logic [numNeurons-1:0] actValid;
	logic creditAvail;

	featureLoader uLoader (
		.clk(clk),
		.reset(reset),
		.featData(featData),
		.featValid(featValid),
		.featLast(featLast),
		.featReady(featReady),
		.creditAvail(creditAvail),
		.vecData(vecData),
		.vecValid(vecValid),
		.frameError(frameError)
	);

	////////////////////////////////////////
	// Neuron array
	////////////////////////////////////////

	for (genvar n = 0; n < numNeurons; n++)
	begin : gNeuron
		reluNeuron #(.weightRow(n)) uNeuron (
			.clk(clk),
			.reset(reset),
			.vecData(vecData), // Same vector to every node.
			.vecValid(vecValid),
			.act(actData[n]),
			.actValid(actValid[n])
		);
	end

	activationCollector uCollector (
		.clk(clk),
		.reset(reset),
		.vecValid(vecValid),
		.actData(actData),
		.actValid(actValid),
		.creditAvail(creditAvail),
		.outData(outData),
		.outIndex(outIndex),
		.outClass(outClass),
		.outLast(outLast),
		.outValid(outValid),
		.outReady(outReady)
	);

endmodule

// ==== include/layerTestTable.svh ====
`ifndef LAYER_TEST_TABLE_SVH
`define LAYER_TEST_TABLE_SVH

// Columns are features, bad framing, random features, expected activations, expected class.
// Features are Q13, so 32'h2000 is 1.0 and 32'hFFFF_E000 is -1.0.

localparam int numRows = 10;

localparam logic [nnFormatPkg::dataWidth-1:0] rowFeat [numRows][nnFormatPkg::numInputs] = '{
	'{default: 32'h0}, // Ties everywhere.
	'{default: 32'hFFFF_E000}, // Every sum negative.
	'{32'h2000, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0},
	'{default: 32'h2000},
	'{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 32'h2000, 0, 0},
	'{default: 32'h0},
	'{default: 32'h0},
	'{default: 32'h0},
	'{default: 32'h0},
	'{default: 32'h0}
};

// featLast lands on the wrong beat.
localparam bit rowBadFrame [numRows] = '{0, 0, 0, 0, 0, 0, 0, 0, 1, 0};

// Features are drawn at run time.
localparam bit rowRandom [numRows] = '{0, 0, 0, 0, 0, 1, 1, 1, 0, 1};

localparam logic [nnFormatPkg::actWidth-1:0] rowAct [numRows][nnFormatPkg::numNeurons] = '{
	'{default: 16'h0},
	'{default: 16'h0},
	'{1318, 0, 3084, 0, 4731, 0, 2568, 1744},
	'{18342, 8409, 9521, 14840, 7330, 5293, 11354, 5692},
	'{0, 833, 5339, 0, 1478, 2702, 3872, 0},
	'{default: 16'h0},
	'{default: 16'h0},
	'{default: 16'h0},
	'{default: 16'h0},
	'{default: 16'h0}
};

localparam int rowClass [numRows] = '{0, 0, 4, 0, 2, 0, 0, 0, 0, 0};

`endif

// ==== bench/denseLayerTb.sv ====
`timescale 1ns/1ps

module denseLayerTb;
	import nnFormatPkg::*;
	import nnWeightsPkg::*;

	`include "layerTestTable.svh"

	localparam int watchdogCycles = numRows * 200;
	localparam int badLastBeat = 6;

	logic clk = 1'b0;
	logic reset;
	logic [dataWidth-1:0] featData;
	logic featValid;
	logic featLast;
	logic featReady;
	logic [actWidth-1:0] outData;
	logic [classWidth-1:0] outIndex;
	logic [classWidth-1:0] outClass;
	logic outLast;
	logic outValid;
	logic outReady;
	logic frameError;

	logic [dataWidth-1:0] stimFeat [numRows][numInputs];
	logic [actWidth-1:0] expAct [numRows][numNeurons];
	int expClass [numRows];
	int errorCount = 0;
	int rowErrors = 0;
	int rowsPassed = 0;
	int rowsFailed = 0;
	bit sawStall = 1'b0;

	always #5 clk = ~clk;

	denseLayerTop u_denseLayerTop (
		.clk(clk),
		.reset(reset),
		.featData(featData),
		.featValid(featValid),
		.featLast(featLast),
		.featReady(featReady),
		.outData(outData),
		.outIndex(outIndex),
		.outClass(outClass),
		.outLast(outLast),
		.outValid(outValid),
		.outReady(outReady),
		.frameError(frameError)
	);

	////////////////////////////////////////
	// Expected values
	////////////////////////////////////////

	// Weighted sum plus bias in 32 bits, then the rectifier and the Q13 slice.
	function automatic logic [actWidth-1:0] referenceActivation(input int row, input int n);
		logic [dataWidth-1:0] sum;
		logic [actWidth-1:0] result;
		sum = layerBias[n];
		for (int i = 0; i < numInputs; i++)
			sum = sum + stimFeat[row][i] * layerWeights[n][i];
		result = sum[dataWidth-1] ? '0 : sum[fracBits+actWidth-1:fracBits];
		return result;
	endfunction

	function automatic int bestClass(input int row);
		int best;
		best = 0;
		for (int n = 1; n < numNeurons; n++)
			if (expAct[row][n] > expAct[row][best])
				best = n; // Lowest index keeps a tie.
		return best;
	endfunction

	task automatic buildExpected();
		int value;
		for (int row = 0; row < numRows; row++)
		begin
			for (int i = 0; i < numInputs; i++)
			begin
				value = int'($urandom_range(32767)) - 16384; // Within +-2.0.
				stimFeat[row][i] = rowRandom[row] ? dataWidth'(value) : rowFeat[row][i];
			end
			for (int n = 0; n < numNeurons; n++)
				expAct[row][n] = referenceActivation(row, n);
			expClass[row] = bestClass(row);
			if (!rowRandom[row])
			begin
				for (int n = 0; n < numNeurons; n++)
					assert (expAct[row][n] == rowAct[row][n])
					else
					begin
						$display("error: rowAct row %0d neuron %0d is %h, rule gives %h",
							row, n, rowAct[row][n], expAct[row][n]);
						errorCount++;
					end
				assert (expClass[row] == rowClass[row])
				else
				begin
					$display("error: rowClass row %0d is %h, rule gives %h",
						row, rowClass[row], expClass[row]);
					errorCount++;
				end
			end
		end
	endtask

	////////////////////////////////////////
	// Feature stream
	////////////////////////////////////////

	// Rows go out back to back with featValid never dropping.
	task automatic sendRows();
		bit badSoFar;
		badSoFar = 1'b0;
		for (int row = 0; row < numRows; row++)
		begin
			for (int b = 0; b < numInputs; b++)
			begin
				featData = stimFeat[row][b];
				featValid = 1'b1;
				featLast = rowBadFrame[row] ? (b == badLastBeat) : (b == numInputs - 1);
				while (!featReady)
				begin
					sawStall = 1'b1;
					@(negedge clk);
				end
				@(negedge clk);
			end
			badSoFar = badSoFar || rowBadFrame[row];
			assert (frameError == badSoFar)
			else
			begin
				$display("error: frameError after row %0d got %h expected %h",
					row, frameError, badSoFar);
				errorCount++;
			end
		end
		featValid = 1'b0;
		featLast = 1'b0;
	endtask

	////////////////////////////////////////
	// Output stream
	////////////////////////////////////////

	task automatic checkBeat(input int row, input int beat);
		assert (outData == expAct[row][beat])
		else
		begin
			$display("error: outData row %0d beat %0d got %h expected %h",
				row, beat, outData, expAct[row][beat]);
			rowErrors++;
		end
		assert (outIndex == classWidth'(beat))
		else
		begin
			$display("error: outIndex row %0d got %h expected %h", row, outIndex, beat);
			rowErrors++;
		end
		assert (outClass == classWidth'(expClass[row]))
		else
		begin
			$display("error: outClass row %0d got %h expected %h", row, outClass, expClass[row]);
			rowErrors++;
		end
		assert (outLast == (beat == numNeurons - 1))
		else
		begin
			$display("error: outLast row %0d beat %0d got %h expected %h",
				row, beat, outLast, beat == numNeurons - 1);
			rowErrors++;
		end
	endtask

	task automatic reportRow(input int row);
		if (rowErrors == 0)
		begin
			$display("row %0d: eight beats match, class %0d", row, expClass[row]);
			rowsPassed++;
		end
		else
		begin
			$display("row %0d: %0d mismatches", row, rowErrors);
			rowsFailed++;
		end
		errorCount += rowErrors;
		rowErrors = 0;
	endtask

	task automatic checkOutput();
		int row;
		int beat;
		int stretchLeft;
		bit readyLevel;
		bit holdPending;
		logic [actWidth-1:0] heldData;
		row = 0;
		beat = 0;
		stretchLeft = 60; // Long first stall to use up every credit.
		readyLevel = 1'b0;
		holdPending = 1'b0;
		heldData = '0;
		while (row < numRows)
		begin
			@(negedge clk);
			if (holdPending)
			begin
				assert (outValid && outData == heldData)
				else
				begin
					$display("error: outValid outData under back-pressure got %h %h expected 1 %h",
						outValid, outData, heldData);
					rowErrors++;
				end
			end
			if (stretchLeft == 0)
			begin
				readyLevel = !readyLevel;
				stretchLeft = readyLevel ? int'($urandom_range(12, 1)) : int'($urandom_range(16, 1));
			end
			stretchLeft--;
			outReady = readyLevel;
			holdPending = outValid && !outReady;
			heldData = outData;
			if (outValid && outReady)
			begin
				checkBeat(row, beat);
				if (beat == numNeurons - 1)
				begin
					reportRow(row);
					row++;
					beat = 0;
				end
				else
					beat++;
			end
		end
		@(negedge clk); // Let the last beat transfer.
		outReady = 1'b0;
	endtask

	////////////////////////////////////////
	// Run
	////////////////////////////////////////

	initial
	begin
		void'($urandom(32'hce9ad7f8));
		reset = 1'b1;
		featData = '0;
		featValid = 1'b0;
		featLast = 1'b0;
		outReady = 1'b0;
		buildExpected();
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		assert (featReady && !outValid && !frameError)
		else
		begin
			$display("error: after reset featReady %h outValid %h frameError %h, expected 1 0 0",
				featReady, outValid, frameError);
			errorCount++;
		end
		fork
			sendRows();
			checkOutput();
		join
		assert (sawStall)
		else
		begin
			$display("featReady never fell while outReady was held low");
			errorCount++;
		end
		assert (featReady)
		else
		begin
			$display("featReady did not come back after the last frame");
			errorCount++;
		end
		assert (!outValid)
		else
		begin
			$display("error: outValid after the last row got %h expected 0", outValid);
			errorCount++;
		end
		$display("rows passed %0d, rows failed %0d, errors %0d", rowsPassed, rowsFailed, errorCount);
		if (errorCount == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	initial
	begin
		repeat (watchdogCycles) @(posedge clk);
		$display("timeout: not every row came out within %0d cycles", watchdogCycles);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== denseLayerTop.f ====
+incdir+include
hw/nnFormatPkg.sv
hw/nnWeightsPkg.sv
hw/featureLoader.sv
hw/reluNeuron.sv
hw/activationCollector.sv
hw/denseLayerTop.sv
bench/denseLayerTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP := denseLayerTb
FILELIST := denseLayerTop.f
BUILD_DIR := obj_dir
LOG := sim.log
PASS_MSG := TEST RESULT: PASS
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS := --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

# The run passes only when the log holds the pass line.
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
